// ==== Makefile ====
TOP := tb_bmd_ep_mem

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and search the log for the pass line"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing -sv -f build.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
hdl/bmd_pkg.sv
hdl/csr_regfile.sv
hdl/dma_perf_monitor.sv
hdl/cpl_tracker.sv
hdl/bmd_ep_mem.sv
tests/tb_bmd_ep_mem.sv

// ==== hdl/bmd_ep_mem.sv ====
// Top of the DMA endpoint register block, joins register file, tracker and monitor
`timescale 1ns/10ps
`default_nettype none

module bmd_ep_mem
   import bmd_pkg::*;
#(
   parameter int CPL_SIZE_W = 21,
   parameter int PERF_W     = 32
) (
   input  wire              clk,
   input  wire              rst_i,
   // Register port
   input  wire csr_idx_e    a_i,
   input  wire              wr_en_i,
   input  wire [31:0]       wr_d_i,
   output logic [31:0]      rd_d_o,
   // Engine controls
   output logic             init_rst_o,
   output dma_desc_t        mwr_desc_o,
   output dma_desc_t        mrd_desc_o,
   output logic [31:0]      mwr_data_o,
   output logic             mwr_zerolen_en_o,
   output logic [3:0]       trn_wait_count_o,
   output logic [31:0]      cpld_data_o,
   output logic             rd_metering_o,
   output logic [7:0]       mwr_wrr_cnt_o,
   output logic [7:0]       mrd_wrr_cnt_o,
   output logic             mrd_done_o,
   // Engine status
   input  wire              mwr_done_i,
   input  wire cpl_status_t cpl_status_i,
   input  wire link_cfg_t   link_cfg_i,
   input  wire              tags_all_back_i
);

   // Performance counts back to the register file
   logic [31:0] mwr_perf;
   logic [31:0] mrd_perf;

   ////////////////////////////////////////////////////////////////////////////
   // Register file
   ////////////////////////////////////////////////////////////////////////////

   csr_regfile u_csr_regfile (
      .clk              (clk),
      .rst_i            (rst_i),
      .a_i              (a_i),
      .wr_en_i          (wr_en_i),
      .wr_d_i           (wr_d_i),
      .rd_d_o           (rd_d_o),
      .mwr_done_i       (mwr_done_i),
      .mrd_done_i       (mrd_done_o),
      .cpl_status_i     (cpl_status_i),
      .link_cfg_i       (link_cfg_i),
      .mwr_perf_i       (mwr_perf),
      .mrd_perf_i       (mrd_perf),
      .init_rst_o       (init_rst_o),
      .mwr_desc_o       (mwr_desc_o),
      .mrd_desc_o       (mrd_desc_o),
      .mwr_data_o       (mwr_data_o),
      .mwr_zerolen_en_o (mwr_zerolen_en_o),
      .trn_wait_count_o (trn_wait_count_o),
      .cpld_data_o      (cpld_data_o),
      .rd_metering_o    (rd_metering_o),
      .mwr_wrr_cnt_o    (mwr_wrr_cnt_o),
      .mrd_wrr_cnt_o    (mrd_wrr_cnt_o)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Read completion tracking
   ////////////////////////////////////////////////////////////////////////////

   cpl_tracker #(
      .CPL_SIZE_W (CPL_SIZE_W)
   ) u_cpl_tracker (
      .clk              (clk),
      .init_rst_i       (init_rst_o),
      .mrd_desc_i       (mrd_desc_o),
      .cpld_data_size_i (cpl_status_i.data_size),
      .tags_all_back_i  (tags_all_back_i),
      .mrd_done_o       (mrd_done_o)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Transfer timing
   ////////////////////////////////////////////////////////////////////////////

   dma_perf_monitor #(
      .PERF_W (PERF_W)
   ) u_dma_perf_monitor (
      .clk         (clk),
      .init_rst_i  (init_rst_o),
      .mwr_start_i (mwr_desc_o.start),
      .mwr_done_i  (mwr_done_i),
      .mrd_start_i (mrd_desc_o.start),
      .mrd_done_i  (mrd_done_o),
      .mwr_perf_o  (mwr_perf),
      .mrd_perf_o  (mrd_perf)
   );

endmodule

`default_nettype wire

// ==== hdl/bmd_pkg.sv ====
// Shared types and constants for the bus-master DMA endpoint register block
`default_nettype none

package bmd_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Identity and reset constants
   ////////////////////////////////////////////////////////////////////////////

   // Width of the DWORD register index
   localparam int CSR_ADDR_W = 7;

   // Identity fields shown in the control register
   localparam logic [7:0] FPGA_FAMILY    = 8'h15;
   localparam logic [3:0] INTERFACE_TYPE = 4'h2;
   localparam logic [7:0] VERSION_NUMBER = 8'h16;

   // Both weighted round-robin counts start here
   localparam logic [7:0] WRR_CNT_RESET = 8'h04;

   ////////////////////////////////////////////////////////////////////////////
   // Register map
   ////////////////////////////////////////////////////////////////////////////

   // DWORD index of each register, any other index reads as zero
   typedef enum logic [CSR_ADDR_W-1:0] {
      REG_CTRL         = 7'd0,
      REG_DMA_CS       = 7'd1,
      REG_MWR_ADDR     = 7'd2,
      REG_MWR_LEN      = 7'd3,
      REG_MWR_COUNT    = 7'd4,
      REG_MWR_DATA     = 7'd5,
      REG_CPL_DATA     = 7'd6,
      REG_MRD_ADDR     = 7'd7,
      REG_MRD_LEN      = 7'd8,
      REG_MRD_COUNT    = 7'd9,
      REG_MWR_PERF     = 7'd10,
      REG_MRD_PERF     = 7'd11,
      REG_CPL_STATUS   = 7'd12,
      REG_CPLD_FOUND   = 7'd13,
      REG_CPLD_SIZE    = 7'd14,
      REG_LINK_WIDTH   = 7'd15,
      REG_LINK_PAYLOAD = 7'd16,
      REG_ARB_CTRL     = 7'd17
   } csr_idx_e;

   ////////////////////////////////////////////////////////////////////////////
   // Grouped signals
   ////////////////////////////////////////////////////////////////////////////

   // One DMA descriptor, same shape for write and read
   typedef struct packed {
      logic [31:0] addr;
      logic [15:0] len;             // Length in DWORDs
      logic [15:0] count;           // Packet count
      logic [2:0]  tc;              // Traffic class
      logic        en_64b;
      logic        phant_func_dis1;
      logic [7:0]  up_addr;         // Upper address byte for 64-bit TLPs
      logic        relaxed;
      logic        nosnoop;
      logic        int_dis;
      logic        start;
   } dma_desc_t;

   // Completion status reported by the receive engine
   typedef struct packed {
      logic [7:0]  ur_found;
      logic [7:0]  ur_tag;
      logic [31:0] found;
      logic [31:0] data_size;
      logic        malformed;
      logic        data_err;
   } cpl_status_t;

   // Negotiated link settings from the config space
   typedef struct packed {
      logic [3:0] lnk_width;
      logic [1:0] max_payload;
      logic [2:0] max_rd_req;
   } link_cfg_t;

endpackage

`default_nettype wire

// ==== hdl/cpl_tracker.sv ====
// Tracks read-DMA completions against the expected size and raises read-done
`timescale 1ns/10ps
`default_nettype none

module cpl_tracker
   import bmd_pkg::*;
#(
   parameter int CPL_SIZE_W = 21
) (
   input  wire            clk,
   input  wire            init_rst_i,
   input  wire dma_desc_t mrd_desc_i,
   input  wire [31:0]     cpld_data_size_i,
   input  wire            tags_all_back_i,
   output logic           mrd_done_o
);

   typedef enum logic [1:0] {
      TRK_IDLE,
      TRK_WAIT,
      TRK_DONE
   } trk_state_e;

   trk_state_e            state_q;
   trk_state_e            state_d;
   logic [31:0]           exp_prod;
   logic [CPL_SIZE_W-1:0] exp_size_q;
   logic [CPL_SIZE_W-1:0] rcv_size_q;
   logic                  size_match_q;
   logic                  all_back;

   ////////////////////////////////////////////////////////////////////////////
   // Size pipeline
   ////////////////////////////////////////////////////////////////////////////

   // Expected DWORDs is length times packet count
   assign exp_prod = 32'(mrd_desc_i.len) * 32'(mrd_desc_i.count);

   always_ff @(posedge clk) begin
      exp_size_q <= exp_prod[CPL_SIZE_W-1:0];
      rcv_size_q <= cpld_data_size_i[CPL_SIZE_W-1:0];
   end

   always_ff @(posedge clk) begin
      if (init_rst_i) begin
         size_match_q <= 1'b0;
      end else begin
         size_match_q <= (exp_size_q == rcv_size_q);
      end
   end

   // Every byte counted and every tag returned
   assign all_back = size_match_q && tags_all_back_i;

   ////////////////////////////////////////////////////////////////////////////
   // Tracker FSM
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      state_d = state_q;
      case (state_q)
         TRK_IDLE: begin
            if (mrd_desc_i.start) begin
               state_d = all_back ? TRK_DONE : TRK_WAIT;
            end
         end
         TRK_WAIT: begin
            // Software dropped the start bit before the data came back
            if (!mrd_desc_i.start) begin
               state_d = TRK_IDLE;
            end else if (all_back) begin
               state_d = TRK_DONE;
            end
         end
         // Sticky until initiator reset
         TRK_DONE: state_d = TRK_DONE;
         default:  state_d = TRK_IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (init_rst_i) begin
         state_q <= TRK_IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   assign mrd_done_o = (state_q == TRK_DONE);

endmodule

`default_nettype wire

// ==== hdl/csr_regfile.sv ====
// Software register file of the DMA endpoint with field decode and registered readback
`timescale 1ns/10ps
`default_nettype none

module csr_regfile
   import bmd_pkg::*;
(
   input  wire              clk,
   input  wire              rst_i,
   // Register port
   input  wire csr_idx_e    a_i,
   input  wire              wr_en_i,
   input  wire [31:0]       wr_d_i,
   output logic [31:0]      rd_d_o,
   // Status from the engines
   input  wire              mwr_done_i,
   input  wire              mrd_done_i,
   input  wire cpl_status_t cpl_status_i,
   input  wire link_cfg_t   link_cfg_i,
   input  wire [31:0]       mwr_perf_i,
   input  wire [31:0]       mrd_perf_i,
   // Control outputs
   output logic             init_rst_o,
   output dma_desc_t        mwr_desc_o,
   output dma_desc_t        mrd_desc_o,
   output logic [31:0]      mwr_data_o,
   output logic             mwr_zerolen_en_o,
   output logic [3:0]       trn_wait_count_o,
   output logic [31:0]      cpld_data_o,
   output logic             rd_metering_o,
   output logic [7:0]       mwr_wrr_cnt_o,
   output logic [7:0]       mrd_wrr_cnt_o
);

   // Read word before the output register
   logic [31:0] rd_word;

   ////////////////////////////////////////////////////////////////////////////
   // Write decode
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst_i) begin
         // Hardware reset holds the initiator in reset
         init_rst_o       <= 1'b1;
         mwr_desc_o       <= '0;
         mrd_desc_o       <= '0;
         mwr_data_o       <= '0;
         mwr_zerolen_en_o <= 1'b0;
         trn_wait_count_o <= '0;
         cpld_data_o      <= '0;
         rd_metering_o    <= 1'b0;
         mwr_wrr_cnt_o    <= WRR_CNT_RESET;
         mrd_wrr_cnt_o    <= WRR_CNT_RESET;
      end else begin
         if (wr_en_i) begin
            case (a_i)
               REG_CTRL: init_rst_o <= wr_d_i[0];
               REG_DMA_CS: begin
                  // Write engine controls in the low half
                  mwr_desc_o.start   <= wr_d_i[0];
                  mwr_desc_o.relaxed <= wr_d_i[5];
                  mwr_desc_o.nosnoop <= wr_d_i[6];
                  mwr_desc_o.int_dis <= wr_d_i[7];
                  // Read engine controls in the high half
                  mrd_desc_o.start   <= wr_d_i[16];
                  mrd_desc_o.relaxed <= wr_d_i[21];
                  mrd_desc_o.nosnoop <= wr_d_i[22];
                  mrd_desc_o.int_dis <= wr_d_i[23];
               end
               REG_MWR_ADDR: mwr_desc_o.addr <= wr_d_i;
               REG_MWR_LEN: begin
                  mwr_desc_o.len             <= wr_d_i[15:0];
                  mwr_desc_o.tc              <= wr_d_i[18:16];
                  mwr_desc_o.en_64b          <= wr_d_i[19];
                  mwr_desc_o.phant_func_dis1 <= wr_d_i[20];
                  mwr_zerolen_en_o           <= wr_d_i[21];
                  mwr_desc_o.up_addr         <= wr_d_i[31:24];
               end
               REG_MWR_COUNT: begin
                  mwr_desc_o.count <= wr_d_i[15:0];
                  trn_wait_count_o <= wr_d_i[19:16];
               end
               REG_MWR_DATA: mwr_data_o <= wr_d_i;
               // Expected payload of read completions
               REG_CPL_DATA: cpld_data_o <= wr_d_i;
               REG_MRD_ADDR: mrd_desc_o.addr <= wr_d_i;
               REG_MRD_LEN: begin
                  mrd_desc_o.len             <= wr_d_i[15:0];
                  mrd_desc_o.tc              <= wr_d_i[18:16];
                  mrd_desc_o.en_64b          <= wr_d_i[19];
                  mrd_desc_o.phant_func_dis1 <= wr_d_i[20];
                  mrd_desc_o.up_addr         <= wr_d_i[31:24];
               end
               REG_MRD_COUNT: mrd_desc_o.count <= wr_d_i[15:0];
               REG_ARB_CTRL: begin
                  rd_metering_o <= wr_d_i[1];
                  mwr_wrr_cnt_o <= wr_d_i[23:16];
                  mrd_wrr_cnt_o <= wr_d_i[31:24];
               end
               // Read-only and unmapped indices ignore writes
               default: ;
            endcase
         end
         // Initiator reset wins over a start written in the same cycle
         if (init_rst_o) begin
            mwr_desc_o.start <= 1'b0;
            mrd_desc_o.start <= 1'b0;
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Readback mux
   ////////////////////////////////////////////////////////////////////////////

   always_comb begin
      case (a_i)
         REG_CTRL:
            rd_word = {FPGA_FAMILY, 4'b0, INTERFACE_TYPE, VERSION_NUMBER, 7'b0, init_rst_o};
         // Control bits read back where they are written
         REG_DMA_CS:
            rd_word = {cpl_status_i.data_err, 6'b0, mrd_done_i,
                       mrd_desc_o.int_dis, mrd_desc_o.nosnoop, mrd_desc_o.relaxed, 4'b0,
                       mrd_desc_o.start,
                       7'b0, mwr_done_i,
                       mwr_desc_o.int_dis, mwr_desc_o.nosnoop, mwr_desc_o.relaxed, 4'b0,
                       mwr_desc_o.start};
         REG_MWR_ADDR: rd_word = mwr_desc_o.addr;
         REG_MWR_LEN:
            rd_word = {mwr_desc_o.up_addr, 2'b0, mwr_zerolen_en_o,
                       mwr_desc_o.phant_func_dis1, mwr_desc_o.en_64b, mwr_desc_o.tc,
                       mwr_desc_o.len};
         REG_MWR_COUNT: rd_word = {12'b0, trn_wait_count_o, mwr_desc_o.count};
         REG_MWR_DATA:  rd_word = mwr_data_o;
         REG_CPL_DATA:  rd_word = cpld_data_o;
         REG_MRD_ADDR:  rd_word = mrd_desc_o.addr;
         REG_MRD_LEN:
            rd_word = {mrd_desc_o.up_addr, 3'b0, mrd_desc_o.phant_func_dis1,
                       mrd_desc_o.en_64b, mrd_desc_o.tc, mrd_desc_o.len};
         REG_MRD_COUNT: rd_word = {16'b0, mrd_desc_o.count};
         // Cycle counts from the monitor
         REG_MWR_PERF: rd_word = mwr_perf_i;
         REG_MRD_PERF: rd_word = mrd_perf_i;
         REG_CPL_STATUS:
            rd_word = {15'b0, cpl_status_i.malformed, cpl_status_i.ur_tag,
                       cpl_status_i.ur_found};
         REG_CPLD_FOUND: rd_word = cpl_status_i.found;
         REG_CPLD_SIZE:  rd_word = cpl_status_i.data_size;
         REG_LINK_WIDTH: rd_word = {26'b0, link_cfg_i.lnk_width, 2'b0};
         REG_LINK_PAYLOAD:
            rd_word = {17'b0, link_cfg_i.max_rd_req, 5'b0, link_cfg_i.max_payload, 5'b0};
         REG_ARB_CTRL:
            rd_word = {mrd_wrr_cnt_o, mwr_wrr_cnt_o, 14'b0, rd_metering_o, 1'b0};
         default: rd_word = '0;
      endcase
   end

   // Readback register, loads every cycle
   always_ff @(posedge clk) begin
      rd_d_o <= rd_word;
   end

endmodule

`default_nettype wire

// ==== hdl/dma_perf_monitor.sv ====
// Cycle counters that time the active write and read DMA transfers
`timescale 1ns/10ps
`default_nettype none

module dma_perf_monitor #(
   parameter int PERF_W = 32
) (
   input  wire         clk,
   input  wire         init_rst_i,
   input  wire         mwr_start_i,
   input  wire         mwr_done_i,
   input  wire         mrd_start_i,
   input  wire         mrd_done_i,
   output logic [31:0] mwr_perf_o,
   output logic [31:0] mrd_perf_o
);

   ////////////////////////////////////////////////////////////////////////////
   // Channel 0 is the write engine, channel 1 the read engine
   ////////////////////////////////////////////////////////////////////////////

   logic [1:0]        start_v;
   logic [1:0]        done_v;
   logic [PERF_W-1:0] cnt_q [2];

   assign start_v = {mrd_start_i, mwr_start_i};
   assign done_v  = {mrd_done_i, mwr_done_i};

   // Count while started and not yet done
   always_ff @(posedge clk) begin
      for (int i = 0; i < 2; i++) begin
         if (init_rst_i) begin
            cnt_q[i] <= '0;
         end else if (start_v[i] && !done_v[i]) begin
            cnt_q[i] <= cnt_q[i] + 1'b1;
         end
      end
   end

   // Zero-extend to the register width
   assign mwr_perf_o = 32'(cnt_q[0]);
   assign mrd_perf_o = 32'(cnt_q[1]);

endmodule

`default_nettype wire

// ==== tests/tb_bmd_ep_mem.sv ====
// Testbench for the DMA endpoint register block with shadow model and self-checks
`timescale 1ns/10ps
`default_nettype none

module tb_bmd_ep_mem
   import bmd_pkg::*;
;

   logic        clk;
   logic        rst_i;
   csr_idx_e    a_i;
   logic        wr_en_i;
   logic [31:0] wr_d_i;
   logic [31:0] rd_d_o;
   logic        init_rst_o;
   dma_desc_t   mwr_desc_o;
   dma_desc_t   mrd_desc_o;
   logic [31:0] mwr_data_o;
   logic        mwr_zerolen_en_o;
   logic [3:0]  trn_wait_count_o;
   logic [31:0] cpld_data_o;
   logic        rd_metering_o;
   logic [7:0]  mwr_wrr_cnt_o;
   logic [7:0]  mrd_wrr_cnt_o;
   logic        mrd_done_o;
   logic        mwr_done_i;
   cpl_status_t cpl_status_i;
   link_cfg_t   link_cfg_i;
   logic        tags_all_back_i;

   // Shadow copy of each written register word
   logic [31:0] sh [0:17];
   logic        exp_mrd_done;
   logic [31:0] lcg_state = 32'hc7b89ba7;
   int          err_cnt = 0;
   int          pass_tests = 0;
   int          fail_tests = 0;

   // Read-write registers hit by the random pass
   csr_idx_e rw_regs [0:9] = '{REG_DMA_CS, REG_MWR_ADDR, REG_MWR_LEN, REG_MWR_COUNT,
      REG_MWR_DATA, REG_CPL_DATA, REG_MRD_ADDR, REG_MRD_LEN, REG_MRD_COUNT, REG_ARB_CTRL};

   bmd_ep_mem #(
      .CPL_SIZE_W (21),
      .PERF_W     (32)
   ) dut_i (
      .clk (clk), .rst_i (rst_i), .a_i (a_i), .wr_en_i (wr_en_i), .wr_d_i (wr_d_i),
      .rd_d_o (rd_d_o), .init_rst_o (init_rst_o), .mwr_desc_o (mwr_desc_o),
      .mrd_desc_o (mrd_desc_o), .mwr_data_o (mwr_data_o),
      .mwr_zerolen_en_o (mwr_zerolen_en_o), .trn_wait_count_o (trn_wait_count_o),
      .cpld_data_o (cpld_data_o), .rd_metering_o (rd_metering_o),
      .mwr_wrr_cnt_o (mwr_wrr_cnt_o), .mrd_wrr_cnt_o (mrd_wrr_cnt_o),
      .mrd_done_o (mrd_done_o), .mwr_done_i (mwr_done_i), .cpl_status_i (cpl_status_i),
      .link_cfg_i (link_cfg_i), .tags_all_back_i (tags_all_back_i)
   );

   // 4 ns clock
   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////////////////////

   function logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Expected read word from the shadow and the current status inputs
   function automatic logic [31:0] exp_read(input csr_idx_e idx);
      logic [31:0] cs;
      cs = sh[REG_DMA_CS] & 32'h00E1_00E1;
      case (idx)
         REG_CTRL:
            return {FPGA_FAMILY, 4'h0, INTERFACE_TYPE, VERSION_NUMBER, 7'h0, sh[REG_CTRL][0]};
         REG_DMA_CS:
            return cs | (32'(mwr_done_i) << 8) | (32'(exp_mrd_done) << 24)
                      | (32'(cpl_status_i.data_err) << 31);
         REG_MWR_ADDR, REG_MWR_DATA, REG_CPL_DATA, REG_MRD_ADDR: return sh[idx];
         // Masks drop the unused bits of each layout
         REG_MWR_LEN:    return sh[idx] & 32'hFF3F_FFFF;
         REG_MWR_COUNT:  return sh[idx] & 32'h000F_FFFF;
         REG_MRD_LEN:    return sh[idx] & 32'hFF1F_FFFF;
         REG_MRD_COUNT:  return sh[idx] & 32'h0000_FFFF;
         REG_ARB_CTRL:   return sh[idx] & 32'hFFFF_0002;
         REG_CPL_STATUS:
            return {15'h0, cpl_status_i.malformed, cpl_status_i.ur_tag, cpl_status_i.ur_found};
         REG_CPLD_FOUND: return cpl_status_i.found;
         REG_CPLD_SIZE:  return cpl_status_i.data_size;
         REG_LINK_WIDTH: return {26'h0, link_cfg_i.lnk_width, 2'h0};
         REG_LINK_PAYLOAD:
            return {17'h0, link_cfg_i.max_rd_req, 5'h0, link_cfg_i.max_payload, 5'h0};
         default: return 32'h0;
      endcase
   endfunction

   // Expected descriptor port from the shadow
   // Read side controls sit 16 bits up in the CS word
   function automatic dma_desc_t exp_desc(input logic rd);
      dma_desc_t   d;
      logic [31:0] cs;
      logic [31:0] ln;
      logic [31:0] cn;
      cs = rd ? (sh[REG_DMA_CS] >> 16) : sh[REG_DMA_CS];
      ln = rd ? sh[REG_MRD_LEN] : sh[REG_MWR_LEN];
      cn = rd ? sh[REG_MRD_COUNT] : sh[REG_MWR_COUNT];
      d.addr            = rd ? sh[REG_MRD_ADDR] : sh[REG_MWR_ADDR];
      d.len             = ln[15:0];
      d.count           = cn[15:0];
      d.tc              = ln[18:16];
      d.en_64b          = ln[19];
      d.phant_func_dis1 = ln[20];
      d.up_addr         = ln[31:24];
      d.relaxed         = cs[5];
      d.nosnoop         = cs[6];
      d.int_dis         = cs[7];
      d.start           = cs[0];
      return d;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Bus tasks and checker entered 1 ns after a rising edge
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_value(input string msg, input logic [127:0] got,
                              input logic [127:0] exp);
      if (got !== exp) begin
         $display("ERR %0t: %s got %0h expected %0h", $time, msg, got, exp);
         err_cnt++;
      end
   endtask

   task automatic idle(input int n);
      repeat (n) @(posedge clk);
      #1;
   endtask

   task automatic reg_write(input csr_idx_e idx, input logic [31:0] d);
      a_i     = idx;
      wr_en_i = 1'b1;
      wr_d_i  = d;
      @(posedge clk);
      #1;
      wr_en_i = 1'b0;
      sh[idx] = d;
      // Initiator reset holds both starts low
      if (sh[REG_CTRL][0]) begin
         sh[REG_DMA_CS][0]  = 1'b0;
         sh[REG_DMA_CS][16] = 1'b0;
      end
   endtask

   task automatic reg_read(input csr_idx_e idx, output logic [31:0] d);
      a_i = idx;
      @(posedge clk);
      #1;
      d = rd_d_o;
   endtask

   task automatic read_check(input csr_idx_e idx);
      logic [31:0] d;
      reg_read(idx, d);
      check_value($sformatf("read of %s", idx.name()), 128'(d), 128'(exp_read(idx)));
   endtask

   task automatic finish_test(input string name, input int errs_before);
      if (err_cnt == errs_before) begin
         pass_tests++;
         $display("Test %s: ok", name);
      end else begin
         fail_tests++;
         $display("Test %s: %0d mismatches", name, err_cnt - errs_before);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////////////////////

   initial begin
      logic [31:0] p0;
      logic [31:0] p1;
      logic [31:0] p2;
      logic [31:0] p3;
      logic [31:0] v;
      logic [95:0] wide;
      logic [15:0] len;
      logic [15:0] cnt;
      int          errs;
      int          n;
      rst_i = 1'b1;
      a_i = REG_CTRL;
      wr_en_i = 1'b0;
      wr_d_i = '0;
      mwr_done_i = 1'b0;
      cpl_status_i = '0;
      link_cfg_i = '0;
      tags_all_back_i = 1'b0;
      exp_mrd_done = 1'b0;
      for (int i = 0; i < 18; i++) sh[i] = '0;
      sh[REG_CTRL] = 32'h1;
      sh[REG_ARB_CTRL] = {WRR_CNT_RESET, WRR_CNT_RESET, 16'h0};
      idle(10);
      rst_i = 1'b0;

      // 1. Reset values
      errs = err_cnt;
      check_value("init_rst_o after reset", 128'(init_rst_o), 128'(1'b1));
      read_check(REG_CTRL);
      read_check(REG_ARB_CTRL);
      read_check(REG_DMA_CS);
      check_value("starts after reset", 128'({mwr_desc_o.start, mrd_desc_o.start}), 128'(0));
      finish_test("1 reset values", errs);

      // 2. Random write and readback of the read-write registers
      errs = err_cnt;
      reg_write(REG_CTRL, next_rand() & 32'hFFFF_FFFE);
      for (int r = 0; r < 3; r++) begin
         foreach (rw_regs[i]) begin
            reg_write(rw_regs[i], next_rand());
            read_check(rw_regs[i]);
         end
      end
      check_value("mwr_desc_o", 128'(mwr_desc_o), 128'(exp_desc(1'b0)));
      check_value("mrd_desc_o", 128'(mrd_desc_o), 128'(exp_desc(1'b1)));
      check_value("mwr_data_o", 128'(mwr_data_o), 128'(sh[REG_MWR_DATA]));
      check_value("mwr_zerolen_en_o", 128'(mwr_zerolen_en_o), 128'(sh[REG_MWR_LEN][21]));
      check_value("trn_wait_count_o", 128'(trn_wait_count_o),
                  128'(sh[REG_MWR_COUNT][19:16]));
      check_value("cpld_data_o", 128'(cpld_data_o), 128'(sh[REG_CPL_DATA]));
      check_value("rd_metering_o", 128'(rd_metering_o), 128'(sh[REG_ARB_CTRL][1]));
      check_value("mwr_wrr_cnt_o", 128'(mwr_wrr_cnt_o), 128'(sh[REG_ARB_CTRL][23:16]));
      check_value("mrd_wrr_cnt_o", 128'(mrd_wrr_cnt_o), 128'(sh[REG_ARB_CTRL][31:24]));
      finish_test("2 register readback", errs);

      // 3. Status views with tags held low so the tracker cannot finish
      errs = err_cnt;
      for (int r = 0; r < 4; r++) begin
         wide = {next_rand(), next_rand(), next_rand()};
         cpl_status_i = wide[81:0];
         v = next_rand();
         link_cfg_i = v[8:0];
         read_check(REG_CPL_STATUS);
         read_check(REG_CPLD_FOUND);
         read_check(REG_CPLD_SIZE);
         read_check(REG_LINK_WIDTH);
         read_check(REG_LINK_PAYLOAD);
         read_check(REG_DMA_CS);
      end
      reg_read(csr_idx_e'(7'd100), v);
      check_value("unused index", 128'(v), 128'(0));
      finish_test("3 status views", errs);

      // 4. Read DMA completes when the size matches and all tags are back
      errs = err_cnt;
      reg_write(REG_DMA_CS, 32'h0);
      // Counter base before the read engine starts
      reg_read(REG_MRD_PERF, p2);
      v = next_rand();
      len = {10'h0, v[5:0]} + 16'd1;
      cnt = {12'h0, v[11:8]} + 16'd1;
      reg_write(REG_MRD_LEN, {v[31:16], len});
      reg_write(REG_MRD_COUNT, {16'h0, cnt});
      reg_write(REG_DMA_CS, 32'h0001_0000);
      idle(3);
      cpl_status_i.data_size = {16'h0, len} * {16'h0, cnt};
      tags_all_back_i = 1'b1;
      n = 0;
      while (!mrd_done_o && n < 40) begin
         idle(1);
         n++;
      end
      if (!mrd_done_o) begin
         $display("Timeout: read-done did not rise within 40 cycles");
         err_cnt++;
      end else begin
         exp_mrd_done = 1'b1;
      end
      read_check(REG_DMA_CS);
      reg_read(REG_MRD_PERF, p0);
      idle(2);
      reg_read(REG_MRD_PERF, p1);
      // One count per cycle from the start edge up to the edge that raised done
      check_value("mrd perf cycles", 128'(p0 - p2), 128'(3 + n));
      check_value("mrd perf frozen", 128'(p1), 128'(p0));
      tags_all_back_i = 1'b0;
      finish_test("4 read completion", errs);

      // 5. Write DMA timing with one count per cycle until done
      errs = err_cnt;
      reg_write(REG_DMA_CS, 32'h0001_0001);
      reg_read(REG_MWR_PERF, p0);
      idle(5);
      reg_read(REG_MWR_PERF, p1);
      check_value("mwr perf step", 128'(p1 - p0), 128'(6));
      mwr_done_i = 1'b1;
      idle(2);
      reg_read(REG_MWR_PERF, p2);
      idle(3);
      reg_read(REG_MWR_PERF, p3);
      check_value("mwr perf held", 128'(p3), 128'(p2));
      read_check(REG_DMA_CS);
      finish_test("5 write timing", errs);

      // 6. Initiator reset from software clears the engines
      errs = err_cnt;
      reg_write(REG_CTRL, 32'h1);
      exp_mrd_done = 1'b0;
      idle(2);
      check_value("init_rst_o", 128'(init_rst_o), 128'(1'b1));
      check_value("starts", 128'({mwr_desc_o.start, mrd_desc_o.start}), 128'(0));
      check_value("mrd_done_o", 128'(mrd_done_o), 128'(1'b0));
      reg_read(REG_MWR_PERF, p0);
      check_value("mwr perf cleared", 128'(p0), 128'(0));
      reg_read(REG_MRD_PERF, p1);
      check_value("mrd perf cleared", 128'(p1), 128'(0));
      read_check(REG_CTRL);
      read_check(REG_DMA_CS);
      finish_test("6 initiator reset", errs);

      $display("Tests passed: %0d, tests failed: %0d", pass_tests, fail_tests);
      if (err_cnt == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire
